//--- build.f
+incdir+rtl
rtl/alu_pkg.sv
rtl/alu_stage_if.sv
rtl/alu_cond_eval.sv
rtl/alu_datapath.sv
rtl/alu_result_stage.sv
rtl/alu.sv
dv/alu_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
  verilator --binary --timing --top-module alu_tb -f build.f -o alu_sim &&
  ./obj_dir/alu_sim ||
  { echo "ALU simulation did not complete successfully"; exit 1; }

//--- dv/alu_tb.sv
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_tb;
  import alu_pkg::*;

  localparam int DW            = `ALU_DATA_W;
  localparam int HW            = `ALU_HALF_W;
  localparam int NUM_CYCLES    = 2000;
  localparam int RESET_TIMEOUT = 10;

  typedef struct packed {
    op_e           op;
    logic          thread;
    logic          valid;
    logic          en;
    logic          sets;
    logic [DW-1:0] res;
    flags_t        flags;
  } expect_t;

  logic          clk;
  logic          rst;
  logic          data_en;
  logic          set_flags;
  logic          thread;
  logic          except;
  logic          except_thread;
  op_e           op;
  logic          wide;
  cond_e         cond;
  logic [DW-1:0] val1;
  logic [DW-1:0] val2;
  flags_t        flags_in;
  logic [DW-1:0] res;
  flags_t        ret_flags;
  logic          ret_sets_flags;
  logic          ret_en;

  integer  seed;
  logic    prev_except;
  logic    prev_except_thread;
  expect_t pending[$];

  alu alu_i (
    .clk            (clk),
    .rst            (rst),
    .data_en        (data_en),
    .set_flags      (set_flags),
    .thread         (thread),
    .except         (except),
    .except_thread  (except_thread),
    .op             (op),
    .wide           (wide),
    .cond           (cond),
    .val1           (val1),
    .val2           (val2),
    .flags_in       (flags_in),
    .res            (res),
    .ret_flags      (ret_flags),
    .ret_sets_flags (ret_sets_flags),
    .ret_en         (ret_en)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_res(input logic [DW-1:0] got, input logic [DW-1:0] exp,
                           input string ctx);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at %0t: %s res %h, expected %h", $time, ctx, got, exp));
    end
  endtask

  task automatic check_flags(input flags_t got, input flags_t exp, input string ctx);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at %0t: %s flags coaszp %b, expected %b",
                          $time, ctx, got, exp));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string ctx);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at %0t: %s is %b, expected %b", $time, ctx, got, exp));
    end
  endtask

  // x86 style condition with pair index in cc[3:1] and cc[0] negating
  function automatic logic cond_holds(input flags_t f, input logic [3:0] cc);
    logic hit;
    case (cc[3:1])
      3'd0:    hit = f.z;
      3'd1:    hit = f.s;
      3'd2:    hit = !f.c && !f.z;           // above
      3'd3:    hit = !f.c;                   // above or equal
      3'd4:    hit = !f.z && (f.s == f.o);   // greater
      3'd5:    hit = (f.s == f.o);
      3'd6:    hit = f.o;
      default: hit = f.p;
    endcase
    return cc[0] ? !hit : hit;
  endfunction

  function automatic expect_t model_op(input op_e opc, input logic w, input cond_e cc,
                                       input logic [DW-1:0] a, input logic [DW-1:0] b,
                                       input flags_t fin);
    expect_t     e;
    logic [DW:0] full;
    logic [HW:0] half;
    logic [4:0]  nib;
    logic        sub;
    logic        sa;
    logic        sb;
    logic        sr;
    logic        has_flags;
    e         = '0;
    e.op      = opc;
    sub       = (opc == OP_SUB);
    // top bit of the widened difference is the borrow
    full = sub ? {1'b0, a} - {1'b0, b} : {1'b0, a} + {1'b0, b};
    half = sub ? {1'b0, a[HW-1:0]} - {1'b0, b[HW-1:0]} : {1'b0, a[HW-1:0]} + {1'b0, b[HW-1:0]};
    nib  = sub ? {1'b0, a[3:0]} - {1'b0, b[3:0]} : {1'b0, a[3:0]} + {1'b0, b[3:0]};
    case (opc)
      OP_ADD, OP_SUB: begin
        e.res     = w ? full[DW-1:0] : {{(DW-HW){1'b0}}, half[HW-1:0]};
        e.flags.c = w ? full[DW] : half[HW];
        e.flags.a = nib[4];
        sa        = w ? a[DW-1] : a[HW-1];
        sb        = w ? b[DW-1] : b[HW-1];
        sr        = w ? full[DW-1] : half[HW-1];
        e.flags.o = sub ? (sa != sb && sr != sa) : (sa == sb && sr != sa);
      end
      OP_AND:   e.res = a & b;
      OP_OR:    e.res = a | b;
      OP_XOR:   e.res = a ^ b;
      OP_ZXT8:  e.res = {{(DW-8){1'b0}}, b[7:0]};
      OP_ZXT16: e.res = {{(DW-16){1'b0}}, b[15:0]};
      OP_SXT8:  e.res = {{(DW-8){b[7]}}, b[7:0]};
      OP_SXT16: e.res = {{(DW-16){b[15]}}, b[15:0]};
      OP_SXT32: e.res = {{(DW-32){b[31]}}, b[31:0]};
      OP_CMOV:  e.res = cond_holds(fin, cc) ? b : a;
      OP_CSET:  e.res = {{(DW-1){1'b0}}, cond_holds(fin, cc)};
      default:  e.res = b;  // mov
    endcase
    if (!w && !(opc inside {OP_ZXT8, OP_ZXT16, OP_SXT8, OP_SXT16, OP_SXT32})) begin
      e.res[DW-1:HW] = '0;
    end
    has_flags = opc inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
    if (has_flags) begin
      e.flags.s = w ? e.res[DW-1] : e.res[HW-1];
      e.flags.z = (e.res == '0);
      e.flags.p = ~^e.res[7:0];
    end
    return e;
  endfunction

  task automatic set_idle();
    data_en       = 1'b0;
    set_flags     = 1'b0;
    thread        = 1'b0;
    except        = 1'b0;
    except_thread = 1'b0;
    op            = OP_ADD;
    wide          = 1'b0;
    cond          = COND_Z;
    val1          = '0;
    val2          = '0;
    flags_in      = '0;
  endtask

  task automatic drive_op();
    logic [31:0] r;
    logic        kill;
    expect_t     e;
    r             = $random(seed);
    data_en       = (r[2:0] != 3'd0);
    set_flags     = (r[4:3] != 2'd0);
    thread        = r[5];
    except        = (r[8:6] == 3'd0);
    except_thread = r[9];
    wide          = r[10];
    cond          = cond_e'(r[14:11]);
    flags_in      = flags_t'(r[20:15]);
    op            = op_e'(4'(r[31:21] % 11'd13));
    val1          = {$random(seed), $random(seed)};
    val2          = {$random(seed), $random(seed)};
    r             = $random(seed);
    case (r[2:0])
      3'd0:    val2 = val1;                    // sub to zero without borrow
      3'd1:    val2 = '0;
      3'd2:    val1 = '0;                      // borrow on sub
      3'd3:    val1 = '1;                      // carry out on add
      3'd4:    val2[HW-1:0] = val1[HW-1:0];    // narrow zero with differing upper halves
      default: ;
    endcase
    kill = (except && except_thread == thread) ||
           (prev_except && prev_except_thread == thread);
    e = model_op(op, wide, cond, val1, val2, flags_in);
    if (!(set_flags && data_en)) begin
      e.flags = '0;
    end
    e.sets   = set_flags && data_en;
    e.en     = data_en && !kill;
    e.valid  = data_en;
    e.thread = thread;
    pending.push_back(e);
    prev_except        = except;
    prev_except_thread = except_thread;
  endtask

  task automatic check_outputs(input expect_t e);
    string ctx;
    ctx = $sformatf("%s thread %0d", e.op.name(), e.thread);
    check_bit(ret_en, e.en, {ctx, " ret_en"});
    check_bit(ret_sets_flags, e.sets, {ctx, " ret_sets_flags"});
    check_flags(ret_flags, e.flags, ctx);
    if (e.valid) begin
      check_res(res, e.res, ctx);
    end
  endtask

  initial begin
    int n;
    seed               = 82586;
    prev_except        = 1'b0;
    prev_except_thread = 1'b0;
    rst                = 1'b1;
    set_idle();
    for (n = 0; n < 3; n++) begin
      @(posedge clk);
    end
    #1;
    rst = 1'b0;
    n = 0;
    while (ret_en !== 1'b0 || ret_sets_flags !== 1'b0 || ret_flags !== '0) begin
      if (n >= RESET_TIMEOUT) begin
        abort_run("timeout: retire outputs never went idle after reset");
      end
      @(posedge clk);
      #1;
      n++;
    end
    for (n = 0; n < 4; n++) begin  // no op issued yet
      @(posedge clk);
      #1;
      check_bit(ret_en, 1'b0, "idle ret_en");
      check_bit(ret_sets_flags, 1'b0, "idle ret_sets_flags");
    end
    for (n = 0; n < NUM_CYCLES; n++) begin
      @(posedge clk);
      #1;
      if (pending.size() > 0) begin
        check_outputs(pending.pop_front());
      end
      drive_op();
    end
    while (pending.size() > 0) begin
      @(posedge clk);
      #1;
      check_outputs(pending.pop_front());
      set_idle();
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    data_en,
  input  logic                    set_flags,
  input  logic                    thread,
  input  logic                    except,
  input  logic                    except_thread,
  input  logic [3:0]              op,
  input  logic                    wide,
  input  logic [3:0]              cond,
  input  logic [`ALU_DATA_W-1:0]  val1,
  input  logic [`ALU_DATA_W-1:0]  val2,
  input  logic [`ALU_FLAGS_W-1:0] flags_in,
  output logic [`ALU_DATA_W-1:0]  res,
  output logic [`ALU_FLAGS_W-1:0] ret_flags,
  output logic                    ret_sets_flags,
  output logic                    ret_en
);
  import alu_pkg::*;

  alu_stage_if st_if ();

  alu_datapath datapath_i (
    .a        (val1),
    .b        (val2),
    .op       (op_e'(op)),
    .wide     (wide),
    .cond     (cond_e'(cond)),
    .flags_in (flags_in),
    .st       (st_if.src)
  );

  alu_result_stage result_i (
    .clk            (clk),
    .rst            (rst),
    .st             (st_if.dst),
    .data_en        (data_en),
    .set_flags      (set_flags),
    .thread         (thread),
    .except         (except),
    .except_thread  (except_thread),
    .res            (res),
    .ret_flags      (ret_flags),
    .ret_sets_flags (ret_sets_flags),
    .ret_en         (ret_en)
  );

endmodule

//--- rtl/alu_result_stage.sv
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_result_stage (
  input  logic                   clk,
  input  logic                   rst,
  alu_stage_if.dst               st,
  input  logic                   data_en,
  input  logic                   set_flags,
  input  logic                   thread,
  input  logic                   except,
  input  logic                   except_thread,
  output logic [`ALU_DATA_W-1:0] res,
  output alu_pkg::flags_t        ret_flags,
  output logic                   ret_sets_flags,
  output logic                   ret_en
);
  import alu_pkg::*;

  flag_kind_e kind_q;
  logic       c_q;
  logic       o_q;
  logic       a_q;
  logic       s_q;
  logic       except_q;
  logic       except_thread_q;
  logic       kill;

  // exception now or one cycle ago on this op's thread
  assign kill = (except && except_thread == thread) ||
                (except_q && except_thread_q == thread);

  always_ff @(posedge clk) begin
    if (rst) begin
      res             <= '0;
      kind_q          <= FK_NONE;
      ret_sets_flags  <= 1'b0;
      ret_en          <= 1'b0;
      except_q        <= 1'b0;
      except_thread_q <= 1'b0;
    end else begin
      res             <= st.res;
      kind_q          <= st.kind;
      ret_sets_flags  <= set_flags & data_en;
      ret_en          <= data_en & ~kill;
      except_q        <= except;
      except_thread_q <= except_thread;
    end
  end

  always_ff @(posedge clk) begin
    c_q <= st.c;
    o_q <= st.o;
    a_q <= st.a;
    s_q <= st.s;
  end

  always_comb begin
    ret_flags = '0;
    if (ret_sets_flags && kind_q != FK_NONE) begin
      if (kind_q == FK_ARITH) begin
        ret_flags.c = c_q;
        ret_flags.o = o_q;
        ret_flags.a = a_q;
      end
      ret_flags.s = s_q;
      ret_flags.z = (res == '0);            // narrow ops already zeroed the top
      ret_flags.p = ~^res[`ALU_PAR_W-1:0];  // even parity
    end
  end

endmodule

//--- rtl/alu_datapath.sv
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_datapath (
  input  logic [`ALU_DATA_W-1:0] a,
  input  logic [`ALU_DATA_W-1:0] b,
  input  alu_pkg::op_e           op,
  input  logic                   wide,
  input  alu_pkg::cond_e         cond,
  input  alu_pkg::flags_t        flags_in,
  alu_stage_if.src               st
);
  import alu_pkg::*;

  localparam int DW = `ALU_DATA_W;
  localparam int HW = `ALU_HALF_W;
  localparam int AB = `ALU_AUX_BIT;

  logic          taken;
  logic          is_sub;
  logic          is_ext;
  logic [DW-1:0] b_add;
  logic [DW:0]   sum;
  logic [DW-1:0] res;
  logic          c_half;
  logic          c_aux;
  logic          a_top;
  logic          b_top;
  logic          sum_top;

  alu_cond_eval cond_eval_i (
    .flags (flags_in),
    .cond  (cond),
    .taken (taken)
  );

  assign is_sub = (op == OP_SUB);
  assign is_ext = op inside {OP_ZXT8, OP_ZXT16, OP_SXT8, OP_SXT16, OP_SXT32};

  // sub as a + ~b + 1
  assign b_add = is_sub ? ~b : b;
  assign sum   = {1'b0, a} + {1'b0, b_add} + {{DW{1'b0}}, is_sub};

  // carry into a bit = sum ^ a ^ b at that bit
  assign c_half = sum[HW] ^ a[HW] ^ b_add[HW];
  assign c_aux  = sum[AB+1] ^ a[AB+1] ^ b_add[AB+1];

  assign a_top   = wide ? a[DW-1] : a[HW-1];
  assign b_top   = wide ? b_add[DW-1] : b_add[HW-1];
  assign sum_top = wide ? sum[DW-1] : sum[HW-1];

  always_comb begin
    case (op)
      OP_ADD, OP_SUB: res = sum[DW-1:0];
      OP_AND:         res = a & b;
      OP_OR:          res = a | b;
      OP_XOR:         res = a ^ b;
      OP_MOV:         res = b;
      OP_ZXT8:        res = {{(DW-8){1'b0}}, b[7:0]};
      OP_ZXT16:       res = {{(DW-16){1'b0}}, b[15:0]};
      OP_SXT8:        res = {{(DW-8){b[7]}}, b[7:0]};
      OP_SXT16:       res = {{(DW-16){b[15]}}, b[15:0]};
      OP_SXT32:       res = {{(DW-HW){b[HW-1]}}, b[HW-1:0]};
      OP_CMOV:        res = taken ? b : a;
      OP_CSET:        res = {{(DW-1){1'b0}}, taken};
      default:        res = '0;
    endcase
    // extensions define their own upper half
    if (!wide && !is_ext) begin
      res[DW-1:HW] = '0;
    end
  end

  always_comb begin
    case (op)
      OP_ADD, OP_SUB:         st.kind = FK_ARITH;
      OP_AND, OP_OR, OP_XOR:  st.kind = FK_LOGIC;
      default:                st.kind = FK_NONE;
    endcase
  end

  assign st.res = res;
  assign st.c   = (wide ? sum[DW] : c_half) ^ is_sub; // borrow is inverted carry
  assign st.a   = c_aux ^ is_sub;
  assign st.o   = ~(a_top ^ b_top) & (sum_top ^ a_top);
  assign st.s   = wide ? res[DW-1] : res[HW-1];

endmodule

//--- rtl/alu_cond_eval.sv
`timescale 1ns/1ps

module alu_cond_eval (
  input  alu_pkg::flags_t flags,
  input  alu_pkg::cond_e  cond,
  output logic            taken
);
  import alu_pkg::*;

  logic signed_lt;
  logic base;

  assign signed_lt = flags.s ^ flags.o;

  // positive form of each pair flipped by the low cond bit
  always_comb begin
    case (cond)
      COND_Z, COND_NZ:     base = flags.z;
      COND_S, COND_NS:     base = flags.s;
      COND_UGT, COND_ULE:  base = ~(flags.c | flags.z);
      COND_UGE, COND_ULT:  base = ~flags.c;
      COND_SGT, COND_SLE:  base = ~(signed_lt | flags.z);
      COND_SGE, COND_SLT:  base = ~signed_lt;
      COND_O, COND_NO:     base = flags.o;
      COND_P, COND_NP:     base = flags.p;
      default:             base = 1'b0;
    endcase
  end

  assign taken = base ^ cond[0];

endmodule

//--- rtl/alu_stage_if.sv
`timescale 1ns/1ps
`include "alu_defines.svh"

// datapath outputs handed to the result register
interface alu_stage_if;
  import alu_pkg::*;

  logic [`ALU_DATA_W-1:0] res;
  logic                   c;    // borrow for sub
  logic                   o;
  logic                   a;
  logic                   s;
  flag_kind_e             kind;

  modport src (
    output res, c, o, a, s, kind
  );

  modport dst (
    input res, c, o, a, s, kind
  );

endinterface

//--- rtl/alu_pkg.sv
package alu_pkg;

  typedef enum logic [3:0] {
    OP_ADD   = 4'd0,
    OP_SUB   = 4'd1,
    OP_AND   = 4'd2,
    OP_OR    = 4'd3,
    OP_XOR   = 4'd4,
    OP_MOV   = 4'd5,
    OP_ZXT8  = 4'd6,
    OP_ZXT16 = 4'd7,
    OP_SXT8  = 4'd8,
    OP_SXT16 = 4'd9,
    OP_SXT32 = 4'd10,
    OP_CMOV  = 4'd11,
    OP_CSET  = 4'd12
  } op_e;

  // low bit of each pair inverts the condition
  typedef enum logic [3:0] {
    COND_Z   = 4'd0,  COND_NZ  = 4'd1,
    COND_S   = 4'd2,  COND_NS  = 4'd3,
    COND_UGT = 4'd4,  COND_ULE = 4'd5,
    COND_UGE = 4'd6,  COND_ULT = 4'd7,
    COND_SGT = 4'd8,  COND_SLE = 4'd9,
    COND_SGE = 4'd10, COND_SLT = 4'd11,
    COND_O   = 4'd12, COND_NO  = 4'd13,
    COND_P   = 4'd14, COND_NP  = 4'd15
  } cond_e;

  typedef enum logic [1:0] {
    FK_NONE  = 2'd0,
    FK_ARITH = 2'd1,
    FK_LOGIC = 2'd2
  } flag_kind_e;

  typedef struct packed {
    logic c;
    logic o;
    logic a;
    logic s;
    logic z;
    logic p;
  } flags_t;

endpackage

//--- rtl/alu_defines.svh
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// operand and result width
`define ALU_DATA_W 64

// narrow op width with the upper half zeroed
`define ALU_HALF_W 32

// c o a s z p
`define ALU_FLAGS_W 6

// aux carry taken out of this bit
`define ALU_AUX_BIT 3

// parity looks at the low byte only
`define ALU_PAR_W 8

`endif
